/* design/mcs_io_params.svh */
// Shared constants for the processor I/O bridge
// Include wherever window numbers, register offsets or widths are needed
`ifndef MCS_IO_PARAMS_SVH
`define MCS_IO_PARAMS_SVH
`default_nettype none

// Address windows, selected by address bits 11:8
`define MCS_DMA_WINDOWS   4
`define MCS_CTRL_WINDOW   8

`define MCS_OFFSET_W      6
`define MCS_RING_IDX_W    12
`define MCS_IRQ_W         16
`define MCS_IRQ_EXT       4
`define MCS_IRQ_RING_BIT  15

// Control window register offsets
`define REG_IRQ_STAT       6'h00
`define REG_RING_EN        6'h08
`define REG_IN_BASE        6'h10
`define REG_IN_CONS_ADDR   6'h14
`define REG_IN_PROD        6'h18
`define REG_IN_CONS        6'h1C
`define REG_OUT_BASE       6'h20
`define REG_OUT_PROD_ADDR  6'h24
`define REG_OUT_CONS       6'h28
`define REG_OUT_PROD       6'h2C

`default_nettype wire
`endif

/* design/io_bus_pkg.sv */
// Types for the processor strobe/ready I/O bus
// A request word carries one access as seen in its strobe cycle
`include "mcs_io_params.svh"
`default_nettype none

package io_bus_pkg;

   // Same 32-bit address seen raw or split into window and offset
   typedef union packed
   {
      logic [31:0] raw;
      struct packed
      {
         logic [19:0]               hi;
         logic [3:0]                window;
         logic [1:0]                rsvd;
         logic [`MCS_OFFSET_W-1:0]  offset;
      } f;
   } io_addr_u;

   // One bus access of 66 bits
   typedef struct packed
   {
      logic        valid;     // address strobe
      logic        write;
      io_addr_u    addr;
      logic [31:0] wdata;
   } io_req_t;

endpackage

`default_nettype wire

/* design/ring_pkg.sv */
// Ring buffer types shared by the bridge and the ring manager
// Inband and outband configurations arrive as packed structs
`include "mcs_io_params.svh"
`default_nettype none

package ring_pkg;

   typedef logic [`MCS_RING_IDX_W-1:0] ring_idx_t;

   // Inband ring as set up by the ring manager
   typedef struct packed
   {
      logic [31:0] base;
      logic [31:0] cons_addr;
      ring_idx_t   prod_idx;
   } ring_in_cfg_t;

   // Outband ring, consumer side owned by the ring manager
   typedef struct packed
   {
      logic [31:0] base;
      logic [31:0] prod_addr;
      ring_idx_t   cons_idx;
   } ring_out_cfg_t;

endpackage

`default_nettype wire

/* design/dma_window_port.sv */
// Register port towards the four DMA engines
// Decodes windows 0 to 3, raises a one-hot write strobe and picks read data
`timescale 1ns/1ps
`include "mcs_io_params.svh"
`default_nettype none

module dma_window_port
(
   input  io_bus_pkg::io_req_t                  req_i,
   input  logic [`MCS_DMA_WINDOWS-1:0][31:0]    dma_rdata_i,
   output logic [`MCS_OFFSET_W-1:0]             dma_offset_o,
   output logic [31:0]                          dma_wdata_o,
   output logic [`MCS_DMA_WINDOWS-1:0]          dma_write_o,
   output logic [31:0]                          rd_data_o
);

   logic [3:0] window;

   assign window = req_i.addr.f.window;

   // Offset and data are shared by all engines
   assign dma_offset_o = req_i.addr.f.offset;
   assign dma_wdata_o  = req_i.wdata;

   // Write strobe only in the strobe cycle of a write
   always_comb
   begin
      for (int w = 0; w < `MCS_DMA_WINDOWS; w++)
      begin
         dma_write_o[w] = req_i.valid && req_i.write && (window == 4'(w));
      end
   end

   // Zero when none of the DMA windows is addressed
   always_comb
   begin
      rd_data_o = '0;
      for (int w = 0; w < `MCS_DMA_WINDOWS; w++)
      begin
         if (window == 4'(w))
         begin
            rd_data_o = dma_rdata_i[w];
         end
      end
   end

endmodule

`default_nettype wire

/* design/ring_ctrl_regs.sv */
// Control window of the bridge
// Holds the ring indices written by the processor, the interrupt status
// word, and decodes control-window reads
`timescale 1ns/1ps
`include "mcs_io_params.svh"
`default_nettype none

module ring_ctrl_regs
(
   input  logic                          sys_clk,
   input  logic                          rst_n_i,
   input  io_bus_pkg::io_req_t           req_i,
   input  logic [`MCS_IRQ_EXT-1:0]       dma_irq_i,
   input  ring_pkg::ring_in_cfg_t        ring_in_cfg_i,
   input  ring_pkg::ring_out_cfg_t       ring_out_cfg_i,
   input  logic                          ring_enable_i,
   output logic [31:0]                   rd_data_o,
   output logic [`MCS_IRQ_W-1:0]         intc_irq_o,
   output ring_pkg::ring_idx_t           in_cons_idx_o,
   output ring_pkg::ring_idx_t           out_prod_idx_o
);

   logic                       ctrl_hit;
   logic                       ctrl_wr;
   logic [`MCS_OFFSET_W-1:0]   offset;
   ring_pkg::ring_idx_t        in_cons_q;
   ring_pkg::ring_idx_t        out_prod_q;
   logic [`MCS_IRQ_W-1:0]      irq_d;
   logic [`MCS_IRQ_W-1:0]      irq_q;

   assign offset   = req_i.addr.f.offset;
   assign ctrl_hit = (req_i.addr.f.window == 4'(`MCS_CTRL_WINDOW));
   assign ctrl_wr  = req_i.valid && req_i.write && ctrl_hit;

   // Index registers take the low bits of the write word
   always_ff @(posedge sys_clk)
   begin
      if (!rst_n_i)
      begin
         in_cons_q  <= '0;
         out_prod_q <= '0;
      end
      else
      begin
         if (ctrl_wr && offset == `REG_IN_CONS)
            in_cons_q <= req_i.wdata[`MCS_RING_IDX_W-1:0];
         if (ctrl_wr && offset == `REG_OUT_PROD)
            out_prod_q <= req_i.wdata[`MCS_RING_IDX_W-1:0];
      end
   end

   // DMA irqs in the low bits and pending inband work on the ring bit
   always_comb
   begin
      irq_d = '0;
      irq_d[`MCS_IRQ_EXT-1:0] = dma_irq_i;
      irq_d[`MCS_IRQ_RING_BIT] = (ring_in_cfg_i.prod_idx != in_cons_q);
   end

   always_ff @(posedge sys_clk)
   begin
      if (!rst_n_i)
         irq_q <= '0;
      else
         irq_q <= irq_d;
   end

   // Unmapped offsets and other windows read zero
   always_comb
   begin
      rd_data_o = '0;
      if (ctrl_hit)
      begin
         case (offset)
            `REG_IRQ_STAT:      rd_data_o = 32'(irq_q);
            `REG_RING_EN:       rd_data_o = {31'd0, ring_enable_i};
            `REG_IN_BASE:       rd_data_o = ring_in_cfg_i.base;
            `REG_IN_CONS_ADDR:  rd_data_o = ring_in_cfg_i.cons_addr;
            `REG_IN_PROD:       rd_data_o = 32'(ring_in_cfg_i.prod_idx);
            `REG_IN_CONS:       rd_data_o = 32'(in_cons_q);
            `REG_OUT_BASE:      rd_data_o = ring_out_cfg_i.base;
            `REG_OUT_PROD_ADDR: rd_data_o = ring_out_cfg_i.prod_addr;
            `REG_OUT_CONS:      rd_data_o = 32'(ring_out_cfg_i.cons_idx);
            `REG_OUT_PROD:      rd_data_o = 32'(out_prod_q);
            default:            rd_data_o = '0;
         endcase
      end
   end

   assign intc_irq_o     = irq_q;
   assign in_cons_idx_o  = in_cons_q;
   assign out_prod_idx_o = out_prod_q;

endmodule

`default_nettype wire

/* design/io_read_return.sv */
// Read return stage of the I/O bus
// ORs the DMA and control read words and returns them with a one-cycle
// ready in the cycle after the address strobe
`timescale 1ns/1ps
`default_nettype none

module io_read_return
(
   input  logic        sys_clk,
   input  logic        rst_n_i,
   input  logic        strobe_i,
   input  logic [31:0] dma_rd_i,
   input  logic [31:0] ctrl_rd_i,
   output logic [31:0] io_read_data_o,
   output logic        io_ready_o
);

   logic [31:0] rd_merged;

   // Only one side is non-zero for a mapped window
   assign rd_merged = dma_rd_i | ctrl_rd_i;

   always_ff @(posedge sys_clk)
   begin
      if (!rst_n_i)
      begin
         io_ready_o     <= 1'b0;
         io_read_data_o <= '0;
      end
      else
      begin
         // No stall, so every strobe gets exactly one ready
         io_ready_o <= strobe_i;
         // Hold the last returned word between accesses
         if (strobe_i)
            io_read_data_o <= rd_merged;
      end
   end

endmodule

`default_nettype wire

/* design/mcs_io_top.sv */
// Top level of the processor I/O bridge
// Packs the bus inputs into one request and feeds the DMA window port and
// the control registers side by side; their read words meet in the return stage
`timescale 1ns/1ps
`include "mcs_io_params.svh"
`default_nettype none

module mcs_io_top
(
   input  logic                                  sys_clk,
   input  logic                                  rst_n_i,
   input  logic                                  io_addr_strobe_i,
   input  logic                                  io_write_strobe_i,
   input  logic [31:0]                           io_address_i,
   input  logic [31:0]                           io_write_data_i,
   input  logic [`MCS_DMA_WINDOWS-1:0][31:0]     dma_rdata_i,
   input  logic [`MCS_IRQ_EXT-1:0]               dma_irq_i,
   input  ring_pkg::ring_in_cfg_t                ring_in_cfg_i,
   input  ring_pkg::ring_out_cfg_t               ring_out_cfg_i,
   input  logic                                  ring_enable_i,
   output logic [31:0]                           io_read_data_o,
   output logic                                  io_ready_o,
   output logic [`MCS_OFFSET_W-1:0]              dma_offset_o,
   output logic [31:0]                           dma_wdata_o,
   output logic [`MCS_DMA_WINDOWS-1:0]           dma_write_o,
   output logic [`MCS_IRQ_W-1:0]                 intc_irq_o,
   output ring_pkg::ring_idx_t                   in_cons_idx_o,
   output ring_pkg::ring_idx_t                   out_prod_idx_o
);

   io_bus_pkg::io_req_t req;
   logic [31:0]         dma_rd;
   logic [31:0]         ctrl_rd;

   // Request as seen in the strobe cycle
   assign req.valid    = io_addr_strobe_i;
   assign req.write    = io_write_strobe_i;
   assign req.addr.raw = io_address_i;
   assign req.wdata    = io_write_data_i;

   dma_window_port u_dma_port
   (
      .req_i        (req),
      .dma_rdata_i  (dma_rdata_i),
      .dma_offset_o (dma_offset_o),
      .dma_wdata_o  (dma_wdata_o),
      .dma_write_o  (dma_write_o),
      .rd_data_o    (dma_rd)
   );

   ring_ctrl_regs u_ctrl_regs
   (
      .sys_clk        (sys_clk),
      .rst_n_i        (rst_n_i),
      .req_i          (req),
      .dma_irq_i      (dma_irq_i),
      .ring_in_cfg_i  (ring_in_cfg_i),
      .ring_out_cfg_i (ring_out_cfg_i),
      .ring_enable_i  (ring_enable_i),
      .rd_data_o      (ctrl_rd),
      .intc_irq_o     (intc_irq_o),
      .in_cons_idx_o  (in_cons_idx_o),
      .out_prod_idx_o (out_prod_idx_o)
   );

   io_read_return u_read_return
   (
      .sys_clk        (sys_clk),
      .rst_n_i        (rst_n_i),
      .strobe_i       (req.valid),
      .dma_rd_i       (dma_rd),
      .ctrl_rd_i      (ctrl_rd),
      .io_read_data_o (io_read_data_o),
      .io_ready_o     (io_ready_o)
   );

endmodule

`default_nettype wire

/* test/mcs_io_props.sv */
// Bus timing and DMA strobe properties of the I/O bridge
// Bound to the top level and sampled on every clock edge
`timescale 1ns/1ps
`include "mcs_io_params.svh"
`default_nettype none

module mcs_io_props
(
   input logic                          sys_clk,
   input logic                          rst_n_i,
   input logic                          strobe_i,
   input logic                          write_i,
   input logic [31:0]                   addr_i,
   input logic                          ready_i,
   input logic [`MCS_DMA_WINDOWS-1:0]   dma_write_i
);

   // Every strobe is answered in the next cycle
   ready_follows_strobe: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
      strobe_i |=> ready_i)
      else $error("ready missing one cycle after an address strobe");

   no_ready_without_strobe: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
      !strobe_i |=> !ready_i)
      else $error("ready high without an address strobe one cycle before");

   ready_low_after_reset: assert property (@(posedge sys_clk)
      !rst_n_i |=> !ready_i)
      else $error("ready high right after a reset cycle");

   // A write raises only the bit of its window, none above window 3
   dma_write_window: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
      (strobe_i && write_i) |->
         (dma_write_i == ({{(`MCS_DMA_WINDOWS-1){1'b0}}, 1'b1} << addr_i[11:8])))
      else $error("DMA write vector does not match the addressed window");

   // DMA strobes only in the strobe cycle of a write
   dma_write_in_strobe: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
      (dma_write_i != '0) |-> (strobe_i && write_i))
      else $error("DMA write strobe outside a write strobe cycle");

endmodule

bind mcs_io_top mcs_io_props u_props
(
   .sys_clk     (sys_clk),
   .rst_n_i     (rst_n_i),
   .strobe_i    (io_addr_strobe_i),
   .write_i     (io_write_strobe_i),
   .addr_i      (io_address_i),
   .ready_i     (io_ready_o),
   .dma_write_i (dma_write_o)
);

`default_nettype wire

/* test/mcs_io_tb.sv */
// Testbench for the processor I/O bridge
// Drives bus accesses with LFSR data and checks reads against a register model
`timescale 1ns/1ps
`include "mcs_io_params.svh"
`default_nettype none

module mcs_io_tb;

   localparam int READY_TIMEOUT = 8;

   logic                                 sys_clk;
   logic                                 rst_n_i;
   logic                                 io_addr_strobe_i;
   logic                                 io_write_strobe_i;
   logic [31:0]                          io_address_i;
   logic [31:0]                          io_write_data_i;
   logic [`MCS_DMA_WINDOWS-1:0][31:0]    dma_rdata_i;
   logic [`MCS_IRQ_EXT-1:0]              dma_irq_i;
   ring_pkg::ring_in_cfg_t               ring_in_cfg_i;
   ring_pkg::ring_out_cfg_t              ring_out_cfg_i;
   logic                                 ring_enable_i;
   logic [31:0]                          io_read_data_o;
   logic                                 io_ready_o;
   logic [`MCS_OFFSET_W-1:0]             dma_offset_o;
   logic [31:0]                          dma_wdata_o;
   logic [`MCS_DMA_WINDOWS-1:0]          dma_write_o;
   logic [`MCS_IRQ_W-1:0]                intc_irq_o;
   ring_pkg::ring_idx_t                  in_cons_idx_o;
   ring_pkg::ring_idx_t                  out_prod_idx_o;

   logic [31:0]                lfsr;
   string                      cur_test;
   int                         errors;
   int                         test_errors;
   int                         tests_run;
   int                         tests_failed;
   logic [3:0]                 strobe_wr;
   logic [3:0]                 post_wr;
   logic [5:0]                 strobe_off;
   logic [31:0]                strobe_wd;
   ring_pkg::ring_idx_t        model_in_cons;
   ring_pkg::ring_idx_t        model_out_prod;

   mcs_io_top dut
   (
      .sys_clk           (sys_clk),
      .rst_n_i           (rst_n_i),
      .io_addr_strobe_i  (io_addr_strobe_i),
      .io_write_strobe_i (io_write_strobe_i),
      .io_address_i      (io_address_i),
      .io_write_data_i   (io_write_data_i),
      .dma_rdata_i       (dma_rdata_i),
      .dma_irq_i         (dma_irq_i),
      .ring_in_cfg_i     (ring_in_cfg_i),
      .ring_out_cfg_i    (ring_out_cfg_i),
      .ring_enable_i     (ring_enable_i),
      .io_read_data_o    (io_read_data_o),
      .io_ready_o        (io_ready_o),
      .dma_offset_o      (dma_offset_o),
      .dma_wdata_o       (dma_wdata_o),
      .dma_write_o       (dma_write_o),
      .intc_irq_o        (intc_irq_o),
      .in_cons_idx_o     (in_cons_idx_o),
      .out_prod_idx_o    (out_prod_idx_o)
   );

   always #20 sys_clk = ~sys_clk;

   // Galois LFSR stepped once per bit taken
   task automatic draw(input int nbits, output logic [31:0] val);
      logic lsb;
      val = '0;
      for (int i = 0; i < nbits; i++)
      begin
         lsb = lfsr[0];
         lfsr = lfsr >> 1;
         if (lsb)
            lfsr = lfsr ^ 32'hA300_0000;
         val = {val[30:0], lsb};
      end
   endtask

   task automatic check_val(input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("error %s: expected %h, actual %h", cur_test, exp, act);
         errors++;
         test_errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond)
      else
      begin
         $display("%s: %s", cur_test, what);
         errors++;
         test_errors++;
      end
   endtask

   task automatic finish_test();
      tests_run++;
      if (test_errors == 0)
         $display("test %s: pass", cur_test);
      else
      begin
         $display("test %s: FAIL with %0d errors", cur_test, test_errors);
         tests_failed++;
      end
      test_errors = 0;
   endtask

   function automatic logic [31:0] make_addr(input logic [19:0] hi, input logic [3:0] win,
                                              input logic [5:0] off);
      return {hi, win, 2'b00, off};
   endfunction

   // Status word with DMA irqs in bits 3:0 and pending inband work in bit 15
   function automatic logic [31:0] irq_expect(input logic [3:0] irq);
      return {16'd0, (ring_in_cfg_i.prod_idx != model_in_cons), 11'd0, irq};
   endfunction

   function automatic logic [31:0] ctrl_expect(input logic [5:0] off);
      case (off)
         `REG_IRQ_STAT:      return irq_expect(dma_irq_i);
         `REG_RING_EN:       return {31'd0, ring_enable_i};
         `REG_IN_BASE:       return ring_in_cfg_i.base;
         `REG_IN_CONS_ADDR:  return ring_in_cfg_i.cons_addr;
         `REG_IN_PROD:       return {20'd0, ring_in_cfg_i.prod_idx};
         `REG_IN_CONS:       return {20'd0, model_in_cons};
         `REG_OUT_BASE:      return ring_out_cfg_i.base;
         `REG_OUT_PROD_ADDR: return ring_out_cfg_i.prod_addr;
         `REG_OUT_CONS:      return {20'd0, ring_out_cfg_i.cons_idx};
         `REG_OUT_PROD:      return {20'd0, model_out_prod};
         default:            return 32'd0;
      endcase
   endfunction

   task automatic load_random_inputs();
      logic [31:0]                        v;
      logic [3:0][31:0]                   rd;
      ring_pkg::ring_in_cfg_t             in_cfg;
      ring_pkg::ring_out_cfg_t            out_cfg;
      for (int n = 0; n < 4; n++)
      begin
         draw(32, v);
         rd[n] = v;
      end
      draw(32, v);
      in_cfg.base = v;
      draw(32, v);
      in_cfg.cons_addr = v;
      draw(12, v);
      in_cfg.prod_idx = v[11:0];
      draw(32, v);
      out_cfg.base = v;
      draw(32, v);
      out_cfg.prod_addr = v;
      draw(12, v);
      out_cfg.cons_idx = v[11:0];
      @(posedge sys_clk);
      dma_rdata_i    <= rd;
      ring_in_cfg_i  <= in_cfg;
      ring_out_cfg_i <= out_cfg;
      draw(4, v);
      dma_irq_i <= v[3:0];
      draw(1, v);
      ring_enable_i <= v[0];
   endtask

   task automatic wait_ready(output int waits);
      logic got;
      waits = 0;
      got = 1'b0;
      while (!got && waits < READY_TIMEOUT)
      begin
         @(negedge sys_clk);
         waits++;
         got = io_ready_o;
      end
      if (!got)
      begin
         $display("timeout in %s: no ready within %0d cycles of the strobe", cur_test,
                  READY_TIMEOUT);
         $display("Verification failed");
         $finish;
      end
   endtask

   // One access; irq_next is driven in the strobe cycle
   task automatic bus_access(input logic wr, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] irq_next,
                             output logic [31:0] rdata);
      int waits;
      @(posedge sys_clk);
      io_addr_strobe_i  <= 1'b1;
      io_write_strobe_i <= wr;
      io_address_i      <= addr;
      io_write_data_i   <= wdata;
      dma_irq_i         <= irq_next;
      @(negedge sys_clk);
      check_true(!io_ready_o, "ready was high without a preceding strobe");
      strobe_wr  = dma_write_o;
      strobe_off = dma_offset_o;
      strobe_wd  = dma_wdata_o;
      @(posedge sys_clk);
      io_addr_strobe_i  <= 1'b0;
      io_write_strobe_i <= 1'b0;
      wait_ready(waits);
      check_true(waits == 1, "ready did not come exactly one cycle after the strobe");
      rdata = io_read_data_o;
      post_wr = dma_write_o;
      @(negedge sys_clk);
      check_true(!io_ready_o, "ready stayed high for more than one cycle");
   endtask

   task automatic back_to_back(input logic [31:0] addr_a, input logic [31:0] addr_b,
                               output logic [31:0] rd_a, output logic [31:0] rd_b);
      int waits;
      @(posedge sys_clk);
      io_addr_strobe_i  <= 1'b1;
      io_write_strobe_i <= 1'b0;
      io_address_i      <= addr_a;
      @(posedge sys_clk);
      io_address_i <= addr_b;
      wait_ready(waits);
      check_true(waits == 1, "first ready of a strobe pair was late");
      rd_a = io_read_data_o;
      @(posedge sys_clk);
      io_addr_strobe_i <= 1'b0;
      @(negedge sys_clk);
      check_true(io_ready_o, "second strobe of a pair got no ready in the next cycle");
      rd_b = io_read_data_o;
      @(negedge sys_clk);
      check_true(!io_ready_o, "ready stayed high after a strobe pair");
   endtask

   initial
   begin
      logic [31:0] v;
      logic [31:0] wd;
      logic [31:0] rd;
      logic [31:0] rd_a;
      logic [31:0] rd_b;
      logic [5:0]  off;
      logic [3:0]  irq_a;
      logic [5:0]  offs [10];

      sys_clk = 1'b0;
      rst_n_i = 1'b0;
      io_addr_strobe_i = 1'b0;
      io_write_strobe_i = 1'b0;
      io_address_i = '0;
      io_write_data_i = '0;
      dma_rdata_i = '0;
      dma_irq_i = '0;
      ring_in_cfg_i = '0;
      ring_out_cfg_i = '0;
      ring_enable_i = 1'b0;
      lfsr = 32'hba2be90a;
      errors = 0;
      test_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      model_in_cons = '0;
      model_out_prod = '0;
      offs = '{`REG_IRQ_STAT, `REG_RING_EN, `REG_IN_BASE, `REG_IN_CONS_ADDR, `REG_IN_PROD,
               `REG_IN_CONS, `REG_OUT_BASE, `REG_OUT_PROD_ADDR, `REG_OUT_CONS, `REG_OUT_PROD};

      repeat (4) @(posedge sys_clk);
      rst_n_i <= 1'b1;

      cur_test = "reset_and_ready";
      @(negedge sys_clk);
      check_val(32'd0, 32'(io_ready_o));
      check_val(32'd0, io_read_data_o);
      load_random_inputs();
      back_to_back(make_addr(20'h0, 4'd1, 6'h0), make_addr(20'h0, 4'd2, 6'h4), rd_a, rd_b);
      check_val(dma_rdata_i[1], rd_a);
      check_val(dma_rdata_i[2], rd_b);
      finish_test();

      cur_test = "dma_write";
      for (int n = 0; n < 4; n++)
      begin
         draw(32, wd);
         draw(6, v);
         off = v[5:0];
         draw(20, v);
         bus_access(1'b1, make_addr(v[19:0], 4'(n), off), wd, dma_irq_i, rd);
         check_val(32'd1 << n, 32'(strobe_wr));
         check_val(32'(off), 32'(strobe_off));
         check_val(wd, strobe_wd);
         check_val(32'd0, 32'(post_wr));
      end
      finish_test();

      cur_test = "dma_read";
      for (int n = 0; n < 4; n++)
      begin
         draw(20, v);
         bus_access(1'b0, make_addr(v[19:0], 4'(n), 6'h08), 32'd0, dma_irq_i, rd);
         check_val(dma_rdata_i[n], rd);
         check_val(32'd0, 32'(strobe_wr));
      end
      finish_test();

      // Writes to the index registers and then a read of every control offset
      cur_test = "ctrl_regs";
      draw(32, wd);
      bus_access(1'b1, make_addr(20'h0, 4'd8, `REG_IN_CONS), wd, dma_irq_i, rd);
      model_in_cons = wd[11:0];
      check_val({20'd0, model_in_cons}, {20'd0, in_cons_idx_o});
      draw(32, wd);
      bus_access(1'b1, make_addr(20'h0, 4'd8, `REG_OUT_PROD), wd, dma_irq_i, rd);
      model_out_prod = wd[11:0];
      check_val({20'd0, model_out_prod}, {20'd0, out_prod_idx_o});
      for (int i = 0; i < 10; i++)
      begin
         bus_access(1'b0, make_addr(20'h0, 4'd8, offs[i]), 32'd0, dma_irq_i, rd);
         check_val(ctrl_expect(offs[i]), rd);
      end
      finish_test();

      cur_test = "irq_and_unmapped";
      bus_access(1'b1, make_addr(20'h0, 4'd8, `REG_IN_CONS),
                 {20'd0, ring_in_cfg_i.prod_idx}, dma_irq_i, rd);
      model_in_cons = ring_in_cfg_i.prod_idx;
      draw(4, v);
      irq_a = v[3:0];
      @(posedge sys_clk);
      dma_irq_i <= irq_a;
      // The irq change in the strobe cycle shows up one read later
      bus_access(1'b0, make_addr(20'h0, 4'd8, `REG_IRQ_STAT), 32'd0, ~irq_a, rd);
      check_val(irq_expect(irq_a), rd);
      bus_access(1'b0, make_addr(20'h0, 4'd8, `REG_IRQ_STAT), 32'd0, ~irq_a, rd);
      check_val(irq_expect(~irq_a), rd);
      check_val(irq_expect(~irq_a), 32'(intc_irq_o));
      bus_access(1'b1, make_addr(20'h0, 4'd8, `REG_IN_CONS),
                 {20'd0, ring_in_cfg_i.prod_idx + 12'd1}, dma_irq_i, rd);
      model_in_cons = ring_in_cfg_i.prod_idx + 12'd1;
      bus_access(1'b0, make_addr(20'h0, 4'd8, `REG_IRQ_STAT), 32'd0, dma_irq_i, rd);
      check_val(irq_expect(dma_irq_i), rd);
      check_true(rd[15], "status bit 15 low while the ring indices differ");
      bus_access(1'b0, make_addr(20'h0, 4'd5, 6'h00), 32'd0, dma_irq_i, rd);
      check_val(32'd0, rd);
      bus_access(1'b0, make_addr(20'h0, 4'hC, 6'h10), 32'd0, dma_irq_i, rd);
      check_val(32'd0, rd);
      bus_access(1'b0, make_addr(20'h0, 4'd8, 6'h04), 32'd0, dma_irq_i, rd);
      check_val(32'd0, rd);
      bus_access(1'b0, make_addr(20'h0, 4'd8, 6'h3C), 32'd0, dma_irq_i, rd);
      check_val(32'd0, rd);
      finish_test();

      $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
               tests_run - tests_failed, tests_failed, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+design
design/io_bus_pkg.sv
design/ring_pkg.sv
design/dma_window_port.sv
design/ring_ctrl_regs.sv
design/io_read_return.sv
design/mcs_io_top.sv
test/mcs_io_props.sv
test/mcs_io_tb.sv

/* run.sh */
#!/bin/sh
# Build the bridge testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -f flist.f --top-module mcs_io_tb -o mcs_io_sim \
   > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/mcs_io_sim > sim.log 2>&1 || echo "Verification failed" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
